// File: alu_exec_cases.txt
// inst rs1 rs2 rd tag mode expected ; mode 1 waits for all write-backs first
// first word is the case count ; pc of case k is 0x1000 + 4*k
00000030
fff00093 00 00 01 0 1 ffffffff
80000137 00 00 02 1 0 80000000
12300193 00 00 03 2 0 00000123
00700213 00 00 04 3 1 00000007
// immediate forms
0000a293 01 00 05 4 0 00000001
fff1b313 03 00 06 5 0 00000001
0ff1c393 03 00 07 6 0 000001dc
7f026413 04 00 08 7 0 000007f7
ff00f493 01 00 09 8 0 fffffff0
01c21513 04 00 0a 9 0 70000000
00415593 02 00 0b a 0 08000000
40415613 02 00 0c b 0 f8000000
12345697 00 00 0d c 0 12346030
// register forms, x0 write then x0 read
00208733 01 02 0e d 0 7fffffff
404107b3 02 04 0f e 0 7ffffff9
00409833 01 04 10 f 0 ffffff80
004158b3 02 04 11 0 0 01000000
40415933 02 04 12 1 0 ff000000
001129b3 02 01 13 2 0 00000001
0020ba33 01 02 14 3 0 00000000
0030cab3 01 03 15 4 0 fffffedc
00316b33 02 03 16 5 0 80000123
0030f033 01 03 00 6 0 00000000
00300bb3 00 03 17 7 0 00000123
// dependency chains on x24 and x25
00100c13 00 00 18 8 1 00000001
018c0c33 18 18 18 9 0 00000002
018c0c33 18 18 18 a 0 00000004
00300c93 00 00 19 b 0 00000003
002c1c13 18 00 18 c 0 00000010
419c0cb3 18 19 19 d 0 0000000d
00000d13 00 00 1a e 0 00000000
00000d13 00 00 1a f 0 00000000
018ccdb3 19 18 1b 0 0 0000001d
// multiply
12345e37 00 00 1c 1 0 12345000
ffd00e93 00 00 1d 2 0 fffffffd
03de0f33 1c 1d 1e 3 0 c9631000
02211fb3 02 02 1f 4 0 40000000
0220afb3 01 02 1f 5 0 ffffffff
0210bfb3 01 01 1f 6 0 fffffffe
// divide and remainder
03de4f33 1c 1d 1e 7 0 f9ee9000
024eefb3 1d 04 1f 8 0 fffffffd
0240dfb3 01 04 1f 9 0 24924924
0240ffb3 01 04 1f a 0 00000003
0201cfb3 03 00 1f b 0 ffffffff
0201efb3 03 00 1f c 0 00000123
02114fb3 02 01 1f d 0 80000000
02116f33 02 01 1e e 0 00000000
01ef8d33 1f 1e 1a f 0 80000000

// File: alu_exec.f
alu_exec_pkg.sv
alu_decoder.sv
muldiv_unit.sv
alu_pipe.sv
phys_regfile.sv
alu_exec_top.sv
alu_exec_tb.sv

// File: alu_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec_tb
  import alu_exec_pkg::*;
();

  localparam int MUL_UNROLL      = 8;
  localparam int MAX_CASES       = 64;
  localparam int RESET_CYCLES    = 10;
  localparam int CYCLES_PER_CASE = 40;
  localparam int WORDS_PER_CASE  = 7;
  // Issue to done, in cycles
  localparam int ALU_LAT = 3;
  localparam int MUL_LAT = 2 + XLEN / MUL_UNROLL + 1;
  localparam int DIV_LAT = 2 + XLEN + 1;

  typedef struct packed {
    logic [7:0]       idx;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  data;
    logic [TAG_W-1:0] tag;
    logic [31:0]      cyc;
    logic [7:0]       lat;
  } exp_t;

  logic             clk;
  logic             reset_n;
  issue_t           issue;
  wb_t              wb;
  logic             done;
  logic [TAG_W-1:0] done_tag;
  logic             stall;

  logic [31:0] case_mem [0:WORDS_PER_CASE*MAX_CASES];
  logic        case_bad [0:MAX_CASES-1];
  exp_t        exp_q [$];
  int          n_cases;
  int          n_pass;
  int          n_fail;
  int          n_stray;
  int          n_proto;
  int          cyc;
  logic        stall_seen;
  logic        prev_md;
  int          md_issued;
  int          md_done;
  int          md_issue_cyc;
  int          md_idx;

  alu_exec_top #(
    .MUL_UNROLL (MUL_UNROLL)
  ) dut_i (
    .i_clk      (clk),
    .i_reset_n  (reset_n),
    .i_issue    (issue),
    .o_wb       (wb),
    .o_done     (done),
    .o_done_tag (done_tag),
    .o_stall    (stall)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------
  // Issue side
  // --------------------------------------------------
  task automatic issue_case(input int idx);
    logic [31:0] inst;
    logic        mode;
    logic        md;
    issue_t      s;
    exp_t        e;
    inst = case_mem[1 + WORDS_PER_CASE*idx];
    mode = case_mem[6 + WORDS_PER_CASE*idx][0];
    md   = (inst[6:0] == 7'b0110011) && (inst[31:25] == 7'b0000001);
    @(posedge clk);
    while (stall_seen || prev_md || (mode && exp_q.size() != 0)) begin
      issue   <= '0;
      prev_md = 1'b0;
      @(posedge clk);
    end
    s           = '0;
    s.valid     = 1'b1;
    s.inst      = inst;
    s.pc        = 32'h0000_1000 + 32'(4 * idx);
    s.rs1_valid = 1'b1;
    s.rs1       = case_mem[2 + WORDS_PER_CASE*idx][REG_W-1:0];
    s.rs2_valid = 1'b1;
    s.rs2       = case_mem[3 + WORDS_PER_CASE*idx][REG_W-1:0];
    s.rd_valid  = 1'b1;
    s.rd        = case_mem[4 + WORDS_PER_CASE*idx][REG_W-1:0];
    s.tag       = case_mem[5 + WORDS_PER_CASE*idx][TAG_W-1:0];
    issue <= s;
    e.idx  = 8'(idx);
    e.rd   = s.rd;
    e.tag  = s.tag;
    e.data = case_mem[7 + WORDS_PER_CASE*idx];
    e.cyc  = 32'(cyc + 1); // valid in the coming cycle
    e.lat  = !md ? 8'(ALU_LAT) : inst[14] ? 8'(DIV_LAT) : 8'(MUL_LAT);
    exp_q.push_back(e);
    prev_md = md;
    if (md) begin
      md_issue_cyc = cyc + 1;
      md_idx       = idx;
      md_issued    = md_issued + 1;
    end
  endtask

  // --------------------------------------------------
  // Completion monitor
  // --------------------------------------------------
  task automatic check_completion(input exp_t e);
    if (done_tag !== e.tag) begin
      $display("ERR %0t o_done_tag expected %h got %h", $time, e.tag, done_tag);
      case_bad[e.idx] = 1'b1;
    end
    if (cyc - int'(e.cyc) != int'(e.lat)) begin
      $display("ERR %0t done latency expected %0d got %0d", $time, e.lat, cyc - int'(e.cyc));
      case_bad[e.idx] = 1'b1;
    end
    if (e.rd != '0) begin // x0 writes are dropped by the register file
      if (wb.valid !== 1'b1) begin
        $display("ERR %0t o_wb.valid expected 1 got %b", $time, wb.valid);
        case_bad[e.idx] = 1'b1;
      end
      if (wb.rd !== e.rd) begin
        $display("ERR %0t o_wb.rd expected %0d got %0d", $time, e.rd, wb.rd);
        case_bad[e.idx] = 1'b1;
      end
      if (wb.data !== e.data) begin
        $display("ERR %0t o_wb.data expected %h got %h", $time, e.data, wb.data);
        case_bad[e.idx] = 1'b1;
      end
    end
  endtask

  always @(negedge clk) begin
    exp_t e;
    cyc        = cyc + 1;
    stall_seen = stall;
    if (reset_n) begin
      // Stall must cover the whole muldiv flight
      if (md_issued != md_done && cyc > md_issue_cyc && stall !== 1'b1) begin
        $display("ERR %0t o_stall expected 1 got %b", $time, stall);
        case_bad[md_idx] = 1'b1;
      end
      // And drop once the result is out
      if (md_issued == md_done && stall !== 1'b0) begin
        $display("ERR %0t o_stall expected 0 got %b", $time, stall);
        n_proto = n_proto + 1;
      end
      if (done !== 1'b1 && wb.valid !== 1'b0) begin
        $display("ERR %0t o_wb.valid expected 0 got %b", $time, wb.valid);
        n_proto = n_proto + 1;
      end
      if (done === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Done strobe at %0t with tag %h but nothing was outstanding", $time, done_tag);
          n_stray = n_stray + 1;
        end else begin
          e = exp_q.pop_front();
          check_completion(e);
          if (e.lat != 8'(ALU_LAT)) begin
            md_done = md_done + 1;
          end
          if (case_bad[e.idx]) begin
            n_fail = n_fail + 1;
          end else begin
            n_pass = n_pass + 1;
          end
          $display("case %0d tag %h x%0d = %h : %s", e.idx, e.tag, e.rd, e.data,
                   case_bad[e.idx] ? "FAIL" : "pass");
        end
      end
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int i;
    issue      = '0;
    reset_n    = 1'b0;
    n_pass     = 0;
    n_fail     = 0;
    n_stray    = 0;
    n_proto    = 0;
    cyc        = 0;
    stall_seen = 1'b0;
    prev_md    = 1'b0;
    md_issued  = 0;
    md_done    = 0;
    md_issue_cyc = 0;
    md_idx     = 0;
    for (i = 0; i < MAX_CASES; i++) begin
      case_bad[i] = 1'b0;
    end
    $readmemh("alu_exec_cases.txt", case_mem);
    n_cases = int'(case_mem[0]);
    if (n_cases < 1 || n_cases > MAX_CASES) begin
      $display("Case file could not be read or holds a bad case count");
      $display("Something failed");
      $finish;
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      reset_n <= 1'b1;
      for (i = 0; i < n_cases; i++) begin
        issue_case(i);
      end
      @(posedge clk);
      issue <= '0;
      while (exp_q.size() != 0) @(posedge clk);
      repeat (5) @(posedge clk);
      $display("Cases passed: %0d  failed: %0d  stray done: %0d  protocol errors: %0d",
               n_pass, n_fail, n_stray, n_proto);
      if (n_fail == 0 && n_stray == 0 && n_proto == 0 && n_pass == n_cases) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

  // Watchdog
  initial begin
    #1;
    repeat (RESET_CYCLES + CYCLES_PER_CASE * n_cases) @(posedge clk);
    $display("Watchdog expired with %0d results still outstanding", exp_q.size());
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: alu_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec_top
  import alu_exec_pkg::*;
#(
  parameter int MUL_UNROLL = 8
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  issue_t           i_issue,
  output wb_t              o_wb,
  output logic             o_done,
  output logic [TAG_W-1:0] o_done_tag,
  output logic             o_stall
);

  logic [REG_W-1:0] w_rs1_addr;
  logic [REG_W-1:0] w_rs2_addr;
  logic [XLEN-1:0]  w_rs1_data;
  logic [XLEN-1:0]  w_rs2_data;

  alu_pipe #(
    .MUL_UNROLL (MUL_UNROLL)
  ) u_pipe (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_issue    (i_issue),
    .o_rs1_addr (w_rs1_addr),
    .o_rs2_addr (w_rs2_addr),
    .i_rs1_data (w_rs1_data),
    .i_rs2_data (w_rs2_data),
    .o_wb       (o_wb),
    .o_done     (o_done),
    .o_done_tag (o_done_tag),
    .o_stall    (o_stall)
  );

  phys_regfile u_regfile (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rs1_addr (w_rs1_addr),
    .i_rs2_addr (w_rs2_addr),
    .o_rs1_data (w_rs1_data),
    .o_rs2_data (w_rs2_data),
    .i_wb       (o_wb)
  );

endmodule

`default_nettype wire

// File: phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile
  import alu_exec_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic [REG_W-1:0] i_rs1_addr,
  input  logic [REG_W-1:0] i_rs2_addr,
  output logic [XLEN-1:0]  o_rs1_data,
  output logic [XLEN-1:0]  o_rs2_data,
  input  wb_t              i_wb
);

  localparam int NREG = 2 ** REG_W;

  logic [XLEN-1:0] r_regs [1:NREG-1]; // x0 has no storage

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 1; i < NREG; i++) begin
        r_regs[i] <= '0;
      end
    end else if (i_wb.valid && i_wb.rd != '0) begin
      r_regs[i_wb.rd] <= i_wb.data;
    end
  end

  // Same-cycle write goes straight through
  assign o_rs1_data = (i_rs1_addr == '0)                         ? '0 :
                      (i_wb.valid && i_wb.rd == i_rs1_addr)     ? i_wb.data :
                                                                  r_regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0)                         ? '0 :
                      (i_wb.valid && i_wb.rd == i_rs2_addr)     ? i_wb.data :
                                                                  r_regs[i_rs2_addr];

endmodule

`default_nettype wire

// File: alu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipe
  import alu_exec_pkg::*;
#(
  parameter int MUL_UNROLL = 8
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  issue_t           i_issue,
  output logic [REG_W-1:0] o_rs1_addr,
  output logic [REG_W-1:0] o_rs2_addr,
  input  logic [XLEN-1:0]  i_rs1_data,
  input  logic [XLEN-1:0]  i_rs2_data,
  output wb_t              o_wb,
  output logic             o_done,
  output logic [TAG_W-1:0] o_done_tag,
  output logic             o_stall
);

  localparam int SHAMT_W = $clog2(XLEN);

  function automatic logic is_muldiv(input alu_op_t op);
    return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                      OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

  alu_op_t          w_ex0_op;
  imm_kind_t        w_ex0_imm;

  issue_t           r_ex1_issue;
  alu_op_t          r_ex1_op;
  imm_kind_t        r_ex1_imm;
  logic             w_ex1_muldiv;
  logic [XLEN-1:0]  w_ex1_rs1;
  logic [XLEN-1:0]  w_ex1_rs2;

  issue_t           r_ex2_issue;
  alu_op_t          r_ex2_op;
  imm_kind_t        r_ex2_imm;
  logic             r_ex2_muldiv;
  logic [XLEN-1:0]  r_ex2_rs1_data;
  logic [XLEN-1:0]  r_ex2_rs2_data;
  logic             w_ex2_rs1_fwd;
  logic             w_ex2_rs2_fwd;
  logic [XLEN-1:0]  w_ex2_rs1;
  logic [XLEN-1:0]  w_ex2_rs2;
  logic [XLEN-1:0]  w_ex2_upper;
  logic [XLEN-1:0]  w_ex2_result;

  logic             r_ex3_alu_valid;
  logic             r_ex3_wr;
  logic [REG_W-1:0] r_ex3_rd;
  logic [TAG_W-1:0] r_ex3_tag;
  logic [XLEN-1:0]  r_ex3_result;

  logic             w_md_busy;
  logic             w_md_valid;
  logic [XLEN-1:0]  w_md_res;
  logic [REG_W-1:0] w_md_rd;
  logic [TAG_W-1:0] w_md_tag;

  // --------------------------------------------------
  // EX0
  // --------------------------------------------------
  alu_decoder u_decoder (
    .i_inst (i_issue.inst),
    .o_op   (w_ex0_op),
    .o_imm  (w_ex0_imm)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_op    <= OP_NONE;
      r_ex1_imm   <= IMM_NONE;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_op    <= w_ex0_op;
      r_ex1_imm   <= w_ex0_imm;
    end
  end

  // --------------------------------------------------
  // EX1 register read
  // --------------------------------------------------
  assign o_rs1_addr   = r_ex1_issue.rs1;
  assign o_rs2_addr   = r_ex1_issue.rs2;
  assign w_ex1_muldiv = r_ex1_issue.valid & is_muldiv(r_ex1_op);

  assign w_ex1_rs1 = r_ex1_issue.rs1_valid ? i_rs1_data : '0;

  always_comb begin
    case (r_ex1_imm)
      IMM_I:   w_ex1_rs2 = {{(XLEN-12){r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:20]};
      IMM_SH:  w_ex1_rs2 = {{(XLEN-SHAMT_W){1'b0}}, r_ex1_issue.inst[20 +: SHAMT_W]};
      default: w_ex1_rs2 = r_ex1_issue.rs2_valid ? i_rs2_data : '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_issue  <= '0;
      r_ex2_op     <= OP_NONE;
      r_ex2_imm    <= IMM_NONE;
      r_ex2_muldiv <= 1'b0;
    end else begin
      r_ex2_issue  <= r_ex1_issue;
      r_ex2_op     <= r_ex1_op;
      r_ex2_imm    <= r_ex1_imm;
      r_ex2_muldiv <= w_ex1_muldiv;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_rs1_data <= w_ex1_rs1;
    r_ex2_rs2_data <= w_ex1_rs2;
  end

  // --------------------------------------------------
  // EX2 forwarding and execute
  // --------------------------------------------------
  assign w_ex2_rs1_fwd = o_wb.valid & r_ex2_issue.rs1_valid &
                         (r_ex2_issue.rs1 == o_wb.rd) & (r_ex2_issue.rs1 != '0);
  assign w_ex2_rs2_fwd = o_wb.valid & r_ex2_issue.rs2_valid & (r_ex2_imm == IMM_NONE) &
                         (r_ex2_issue.rs2 == o_wb.rd) & (r_ex2_issue.rs2 != '0);

  assign w_ex2_rs1   = w_ex2_rs1_fwd ? o_wb.data : r_ex2_rs1_data;
  assign w_ex2_rs2   = w_ex2_rs2_fwd ? o_wb.data : r_ex2_rs2_data;
  assign w_ex2_upper = {r_ex2_issue.inst[31:12], 12'h000};

  always_comb begin
    case (r_ex2_op)
      OP_LUI:   w_ex2_result = w_ex2_upper;
      OP_AUIPC: w_ex2_result = r_ex2_issue.pc + w_ex2_upper;
      OP_ADD:   w_ex2_result = w_ex2_rs1 + w_ex2_rs2;
      OP_SUB:   w_ex2_result = w_ex2_rs1 - w_ex2_rs2;
      OP_XOR:   w_ex2_result = w_ex2_rs1 ^ w_ex2_rs2;
      OP_OR:    w_ex2_result = w_ex2_rs1 | w_ex2_rs2;
      OP_AND:   w_ex2_result = w_ex2_rs1 & w_ex2_rs2;
      OP_SLL:   w_ex2_result = w_ex2_rs1 << w_ex2_rs2[SHAMT_W-1:0];
      OP_SRL:   w_ex2_result = w_ex2_rs1 >> w_ex2_rs2[SHAMT_W-1:0];
      OP_SRA:   w_ex2_result = $signed(w_ex2_rs1) >>> w_ex2_rs2[SHAMT_W-1:0];
      OP_SLT:   w_ex2_result = {{(XLEN-1){1'b0}}, $signed(w_ex2_rs1) < $signed(w_ex2_rs2)};
      OP_SLTU:  w_ex2_result = {{(XLEN-1){1'b0}}, w_ex2_rs1 < w_ex2_rs2};
      default:  w_ex2_result = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_alu_valid <= 1'b0;
      r_ex3_wr        <= 1'b0;
    end else begin
      r_ex3_alu_valid <= r_ex2_issue.valid & ~r_ex2_muldiv;
      r_ex3_wr        <= r_ex2_issue.valid & ~r_ex2_muldiv & r_ex2_issue.rd_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_rd     <= r_ex2_issue.rd;
    r_ex3_tag    <= r_ex2_issue.tag;
    r_ex3_result <= w_ex2_result;
  end

  // --------------------------------------------------
  // Muldiv and write-back merge
  // --------------------------------------------------
  muldiv_unit #(
    .MUL_UNROLL (MUL_UNROLL)
  ) u_muldiv (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_start   (r_ex2_muldiv),
    .i_op      (r_ex2_op),
    .i_rd      (r_ex2_issue.rd_valid ? r_ex2_issue.rd : '0),
    .i_tag     (r_ex2_issue.tag),
    .i_rs1     (w_ex2_rs1),
    .i_rs2     (w_ex2_rs2),
    .o_busy    (w_md_busy),
    .o_valid   (w_md_valid),
    .o_res     (w_md_res),
    .o_rd      (w_md_rd),
    .o_tag     (w_md_tag)
  );

  assign o_stall = w_ex1_muldiv | r_ex2_muldiv | w_md_busy;

  always_comb begin
    if (w_md_valid) begin // muldiv owns the bus this cycle
      o_wb.valid = (w_md_rd != '0);
      o_wb.rd    = w_md_rd;
      o_wb.data  = w_md_res;
      o_done_tag = w_md_tag;
    end else begin
      o_wb.valid = r_ex3_wr;
      o_wb.rd    = r_ex3_rd;
      o_wb.data  = r_ex3_result;
      o_done_tag = r_ex3_tag;
    end
  end

  assign o_done = w_md_valid | r_ex3_alu_valid;

  a_wb_no_collision: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(w_md_valid && r_ex3_alu_valid))
    else $error("ALU and muldiv results reached write-back together");

  a_no_issue_in_stall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_issue.valid && o_stall))
    else $error("Valid issue presented while o_stall is high");

endmodule

`default_nettype wire

// File: muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit
  import alu_exec_pkg::*;
#(
  parameter int MUL_UNROLL = 8
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_start,
  input  alu_op_t          i_op,
  input  logic [REG_W-1:0] i_rd,
  input  logic [TAG_W-1:0] i_tag,
  input  logic [XLEN-1:0]  i_rs1,
  input  logic [XLEN-1:0]  i_rs2,
  output logic             o_busy,
  output logic             o_valid,
  output logic [XLEN-1:0]  o_res,
  output logic [REG_W-1:0] o_rd,
  output logic [TAG_W-1:0] o_tag
);

  localparam int CNT_W     = $clog2(XLEN);
  localparam int MUL_STEPS = XLEN / MUL_UNROLL;

  typedef enum logic [1:0] {IDLE, MUL, DIV, DONE} state_t;

  state_t            r_state;
  logic [CNT_W-1:0]  r_cnt;
  alu_op_t           r_op;
  logic [REG_W-1:0]  r_rd;
  logic [TAG_W-1:0]  r_tag;
  logic              r_neg;
  logic              r_div_zero;
  logic [XLEN-1:0]   r_dividend;
  logic [2*XLEN-1:0] r_acc;
  logic [2*XLEN-1:0] r_mcand;
  logic [XLEN-1:0]   r_mplier;
  logic [XLEN-1:0]   r_rem;
  logic [XLEN-1:0]   r_quo;
  logic [XLEN-1:0]   r_divisor;

  logic              w_is_div;
  logic              w_a_neg;
  logic              w_b_neg;
  logic [XLEN-1:0]   w_a_abs;
  logic [XLEN-1:0]   w_b_abs;
  logic [2*XLEN-1:0] w_mul_sum;
  logic [XLEN:0]     w_trial;
  logic [2*XLEN-1:0] w_prod;
  logic [XLEN-1:0]   w_quo;
  logic [XLEN-1:0]   w_rem;

  // Operand magnitudes at start
  assign w_is_div = i_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  assign w_a_neg  = i_rs1[XLEN-1] & (i_op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_DIV, OP_REM});
  assign w_b_neg  = i_rs2[XLEN-1] & (i_op inside {OP_MUL, OP_MULH, OP_DIV, OP_REM});
  assign w_a_abs  = w_a_neg ? -i_rs1 : i_rs1;
  assign w_b_abs  = w_b_neg ? -i_rs2 : i_rs2;

  always_comb begin
    w_mul_sum = r_acc;
    for (int i = 0; i < MUL_UNROLL; i++) begin
      if (r_mplier[i]) begin
        w_mul_sum = w_mul_sum + (r_mcand << i);
      end
    end
  end

  assign w_trial = {r_rem, r_quo[XLEN-1]} - {1'b0, r_divisor};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
      r_cnt   <= '0;
    end else begin
      case (r_state)
        IDLE: if (i_start) begin
          r_state <= w_is_div ? DIV : MUL;
          r_cnt   <= w_is_div ? CNT_W'(XLEN - 1) : CNT_W'(MUL_STEPS - 1);
        end
        MUL, DIV: begin
          r_cnt <= r_cnt - 1'b1;
          if (r_cnt == '0) begin
            r_state <= DONE;
          end
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_state == IDLE && i_start) begin
      r_op       <= i_op;
      r_rd       <= i_rd;
      r_tag      <= i_tag;
      r_neg      <= (i_op inside {OP_REM, OP_REMU}) ? w_a_neg : (w_a_neg ^ w_b_neg);
      r_div_zero <= w_is_div & (i_rs2 == '0);
      r_dividend <= i_rs1;
      r_acc      <= '0;
      r_mcand    <= {{XLEN{1'b0}}, w_a_abs};
      r_mplier   <= w_b_abs;
      r_rem      <= '0;
      r_quo      <= w_a_abs;
      r_divisor  <= w_b_abs;
    end else if (r_state == MUL) begin
      r_acc    <= w_mul_sum;
      r_mcand  <= r_mcand << MUL_UNROLL;
      r_mplier <= r_mplier >> MUL_UNROLL;
    end else if (r_state == DIV) begin
      if (!w_trial[XLEN]) begin // trial subtract fits
        r_rem <= w_trial[XLEN-1:0];
        r_quo <= {r_quo[XLEN-2:0], 1'b1};
      end else begin
        r_rem <= {r_rem[XLEN-2:0], r_quo[XLEN-1]};
        r_quo <= {r_quo[XLEN-2:0], 1'b0};
      end
    end
  end

  // Sign fix-up on the way out
  assign w_prod = r_neg ? -r_acc : r_acc;
  assign w_quo  = r_neg ? -r_quo : r_quo;
  assign w_rem  = r_neg ? -r_rem : r_rem;

  always_comb begin
    case (r_op)
      OP_MUL:                       o_res = w_prod[XLEN-1:0];
      OP_MULH, OP_MULHSU, OP_MULHU: o_res = w_prod[2*XLEN-1:XLEN];
      OP_DIV, OP_DIVU:              o_res = r_div_zero ? '1 : w_quo;
      default:                      o_res = r_div_zero ? r_dividend : w_rem;
    endcase
  end

  assign o_busy  = (r_state != IDLE);
  assign o_valid = (r_state == DONE);
  assign o_rd    = r_rd;
  assign o_tag   = r_tag;

  a_start_when_idle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_start && o_busy))
    else $error("Muldiv start while unit busy");

endmodule

`default_nettype wire

// File: alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decoder
  import alu_exec_pkg::*;
(
  input  logic [31:0] i_inst,
  output alu_op_t     o_op,
  output imm_kind_t   o_imm
);

  localparam logic [6:0] MAJ_OP     = 7'b0110011;
  localparam logic [6:0] MAJ_OP_IMM = 7'b0010011;
  localparam logic [6:0] MAJ_LUI    = 7'b0110111;
  localparam logic [6:0] MAJ_AUIPC  = 7'b0010111;

  logic [2:0] w_funct3;
  logic [6:0] w_funct7;

  assign w_funct3 = i_inst[14:12];
  assign w_funct7 = i_inst[31:25];

  always_comb begin
    o_op  = OP_NONE;
    o_imm = IMM_NONE;
    case (i_inst[6:0])
      MAJ_LUI:   o_op = OP_LUI;
      MAJ_AUIPC: o_op = OP_AUIPC;
      MAJ_OP_IMM: begin
        o_imm = IMM_I;
        case (w_funct3)
          3'b000: o_op = OP_ADD;
          3'b010: o_op = OP_SLT;
          3'b011: o_op = OP_SLTU;
          3'b100: o_op = OP_XOR;
          3'b110: o_op = OP_OR;
          3'b111: o_op = OP_AND;
          3'b001: begin
            o_imm = IMM_SH;
            o_op  = (w_funct7 == 7'b0000000) ? OP_SLL : OP_NONE;
          end
          default: begin // 3'b101, SRLI / SRAI
            o_imm = IMM_SH;
            o_op  = (w_funct7 == 7'b0000000) ? OP_SRL :
                    (w_funct7 == 7'b0100000) ? OP_SRA : OP_NONE;
          end
        endcase
        if (o_op == OP_NONE) begin
          o_imm = IMM_NONE;
        end
      end
      MAJ_OP: begin
        case (w_funct7)
          7'b0000000: begin
            case (w_funct3)
              3'b000:  o_op = OP_ADD;
              3'b001:  o_op = OP_SLL;
              3'b010:  o_op = OP_SLT;
              3'b011:  o_op = OP_SLTU;
              3'b100:  o_op = OP_XOR;
              3'b101:  o_op = OP_SRL;
              3'b110:  o_op = OP_OR;
              default: o_op = OP_AND;
            endcase
          end
          7'b0100000: begin
            if (w_funct3 == 3'b000) begin
              o_op = OP_SUB;
            end else if (w_funct3 == 3'b101) begin
              o_op = OP_SRA;
            end
          end
          7'b0000001: begin // M extension
            case (w_funct3)
              3'b000:  o_op = OP_MUL;
              3'b001:  o_op = OP_MULH;
              3'b010:  o_op = OP_MULHSU;
              3'b011:  o_op = OP_MULHU;
              3'b100:  o_op = OP_DIV;
              3'b101:  o_op = OP_DIVU;
              3'b110:  o_op = OP_REM;
              default: o_op = OP_REMU;
            endcase
          end
          default: o_op = OP_NONE;
        endcase
      end
      default: o_op = OP_NONE;
    endcase
  end

endmodule

`default_nettype wire

// File: alu_exec_pkg.sv
`default_nettype none

package alu_exec_pkg;

  localparam int XLEN  = 32;
  localparam int REG_W = 5;
  localparam int TAG_W = 4;

  typedef enum logic [4:0] {
    OP_NONE,
    OP_LUI,
    OP_AUIPC,
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU,
    OP_MUL,
    OP_MULH,
    OP_MULHSU,
    OP_MULHU,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU
  } alu_op_t;

  // Source of the second operand
  typedef enum logic [1:0] {
    IMM_NONE,
    IMM_I,
    IMM_SH
  } imm_kind_t;

  typedef struct packed {
    logic             valid;
    logic [31:0]      inst;
    logic [31:0]      pc;
    logic             rs1_valid;
    logic [REG_W-1:0] rs1;
    logic             rs2_valid;
    logic [REG_W-1:0] rs2;
    logic             rd_valid;
    logic [REG_W-1:0] rd;
    logic [TAG_W-1:0] tag;
  } issue_t;

  typedef struct packed {
    logic             valid;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  data;
  } wb_t;

endpackage

`default_nettype wire
